// ==== common/fetch_pkg.sv ====
/*
 * fetch front end shared types
 * instruction words, two-slot bundles, per-slot flags and issue queue entries
 */
package fetch_pkg;

	// ==============================
	// fixed widths
	// ==============================
	localparam int ADDR_W = 16;
	localparam int INSTR_W = 16;
	localparam int IMM_W = 14;
	// bundle is always two slots, the validity rules are per pattern
	localparam int SLOT_COUNT = 2;
	localparam int SLOT_BYTES = 2;
	localparam int BUNDLE_BYTES = SLOT_COUNT * SLOT_BYTES;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [INSTR_W-1:0] instr_t;

	// opcode sits in the top two bits of the word
	typedef enum logic [1:0] {
		op_plain = 2'b00,
		op_jump = 2'b01,
		op_return = 2'b10,
		op_branch = 2'b11
	} op_e;

	typedef struct packed {
		logic jc;
		logic rts;
		logic take_branch;
	} slot_flags_t;

	// slot 0 is the lower address and the low half
	typedef struct packed {
		instr_t slot1;
		instr_t slot0;
	} bundle_t;

	typedef struct packed {
		addr_t addr;
		instr_t word;
		op_e op;
	} queue_entry_t;

endpackage

// ==== design/pc_gen.sv ====
/*
 * program counter generator
 * fetch address, next-bundle strobe, redirect selection and the link register
 */
`timescale 1ns/1ps

module pc_gen import fetch_pkg::*; (
	input logic clk,
	input logic rst,
	input logic phit,
	input logic bundle_done,
	input logic pc_override,
	input logic redirect_slot,
	input logic redirect_rts,
	input addr_t slot_target [SLOT_COUNT],
	input logic link_write,
	input addr_t link_addr,
	input logic branchmiss,
	input addr_t miss_target,
	output addr_t fetch_addr,
	output addr_t bundle_addr,
	output logic [1:0] pc_mask,
	output logic nextb
);
	addr_t req_addr;
	addr_t link_reg;
	addr_t redirect_addr;
	addr_t seq_addr;
	logic fresh;

	// bus data is only new when the request did not move last cycle
	assign nextb = phit & bundle_done & fresh;

	// return takes the link, everything else its own decoded target
	assign redirect_addr = redirect_rts ? link_reg : slot_target[redirect_slot];

	// next bundle after the one on the bus, odd entry falls back to slot 0
	assign seq_addr = {req_addr[ADDR_W-1:2], 2'b00} + addr_t'(BUNDLE_BYTES);

	// ==============================
	// request tracking
	// ==============================
	always_ff @(posedge clk) begin
		if (rst) begin
			fetch_addr <= '0;
			req_addr <= '0;
			pc_mask <= 2'b11;
			fresh <= 1'b0;
		end else begin
			// address and mask follow the request by one cycle, like the data
			req_addr <= fetch_addr;
			pc_mask <= fetch_addr[1] ? 2'b10 : 2'b11;
			fresh <= ~(branchmiss | pc_override | nextb);
			// miss beats redirect beats sequential
			if (branchmiss)
				fetch_addr <= miss_target;
			else if (pc_override)
				fetch_addr <= redirect_addr;
			else if (nextb)
				fetch_addr <= seq_addr;
		end
	end

	// captured bundle base and single return entry
	always_ff @(posedge clk) begin
		if (nextb)
			bundle_addr <= {req_addr[ADDR_W-1:2], 2'b00};
		if (link_write)
			link_reg <= link_addr;
	end

endmodule

// ==== design/predecode.sv ====
/*
 * slot predecoder
 * classifies each slot and computes its control-transfer target
 */
`timescale 1ns/1ps

module predecode import fetch_pkg::*; (
	input bundle_t bundle,
	input addr_t bundle_addr,
	output slot_flags_t flags [SLOT_COUNT],
	output addr_t slot_target [SLOT_COUNT],
	output op_e slot_op [SLOT_COUNT]
);
	instr_t word [SLOT_COUNT];

	assign word[0] = bundle.slot0;
	assign word[1] = bundle.slot1;

	for (genvar i = 0; i < SLOT_COUNT; i++) begin : g_slot
		logic [IMM_W-1:0] imm;
		addr_t slot_addr;
		addr_t jump_dest;
		addr_t branch_dest;
		addr_t fall_dest;

		assign slot_addr = bundle_addr + addr_t'(i * SLOT_BYTES);
		assign imm = word[i][IMM_W-1:0];
		assign slot_op[i] = op_e'(word[i][INSTR_W-1:IMM_W]);

		// absolute, halfword aligned
		assign jump_dest = addr_t'({imm, 1'b0});
		// pc relative, sign extended halfword offset
		assign branch_dest = slot_addr + {{(ADDR_W - IMM_W - 1){imm[IMM_W-1]}}, imm, 1'b0};
		// plain and return slots point past themselves
		// the return target comes from the link register instead
		assign fall_dest = slot_addr + addr_t'(SLOT_BYTES);

		assign slot_target[i] = (slot_op[i] == op_jump) ? jump_dest :
			(slot_op[i] == op_branch) ? branch_dest : fall_dest;

		// backward branches only are predicted taken
		assign flags[i] = '{
			jc: slot_op[i] == op_jump,
			rts: slot_op[i] == op_return,
			take_branch: (slot_op[i] == op_branch) & imm[IMM_W-1]
		};
	end

endmodule

// ==== design/slot_valid.sv ====
/*
 * slot validity tracker
 * keeps which slots of the current bundle still have to be queued,
 * stomps the fall-through bundle after a redirect and flags bundle done
 */
`timescale 1ns/1ps

module slot_valid (
	input logic clk,
	input logic rst,
	input logic nextb,
	input logic branchmiss,
	input logic q1,
	input logic q2,
	input logic pc_override,
	input logic [1:0] pc_mask,
	output logic [1:0] slotv,
	output logic [1:0] slotvd,
	output logic bundle_done
);
	// bundle captured this cycle is wrong-path
	logic stomp;

	// ==============================
	// remainder after acceptance
	// ==============================
	always_comb begin
		slotv = slotvd;
		stomp = 1'b0;
		case (slotvd)
			// single slot left, either half
			2'b01, 2'b10: begin
				if (q1) begin
					slotv = 2'b00;
					stomp = pc_override;
				end
			end
			2'b11: begin
				if (q2) begin
					// both gone, slot 1 may be the redirect
					slotv = 2'b00;
					stomp = pc_override;
				end else if (q1) begin
					// slot 0 leaves and slot 1 waits
					// a redirecting slot 0 kills slot 1 too
					slotv = pc_override ? 2'b00 : 2'b10;
					stomp = pc_override;
				end
			end
			default: begin
				slotv = 2'b00;
			end
		endcase
	end

	assign bundle_done = ~|slotv;

	// ==============================
	// registered validity
	// ==============================
	always_ff @(posedge clk) begin
		if (rst) begin
			slotvd <= 2'b00;
		end else if (branchmiss) begin
			// everything in the front end is on the wrong path
			slotvd <= 2'b00;
		end else if (nextb) begin
			// new bundle, unless it is the sequential one behind a redirect
			slotvd <= stomp ? 2'b00 : pc_mask;
		end else begin
			slotvd <= slotv;
		end
	end

endmodule

// ==== design/issue_queue.sv ====
/*
 * issue queue
 * circular buffer taking one or two slots a cycle, drained by valid/ready
 */
`timescale 1ns/1ps

module issue_queue import fetch_pkg::*; #(
	parameter int QUEUE_DEPTH = 4
) (
	input logic clk,
	input logic rst,
	input logic [1:0] slotv,
	input queue_entry_t slot_entry [SLOT_COUNT],
	input slot_flags_t flags [SLOT_COUNT],
	input logic branchmiss,
	input logic issue_ready,
	output logic q1,
	output logic q2,
	output logic pc_override,
	output logic redirect_slot,
	output logic link_write,
	output addr_t link_addr,
	output queue_entry_t issue_entry,
	output logic issue_valid
);
	localparam int PW = $clog2(QUEUE_DEPTH);
	localparam int CW = $clog2(QUEUE_DEPTH + 1);
	localparam logic [CW-1:0] DEPTH_C = CW'(QUEUE_DEPTH);

	queue_entry_t mem [QUEUE_DEPTH];
	logic [PW-1:0] head;
	logic [PW-1:0] tail;
	logic [PW-1:0] tail_1;
	logic [CW-1:0] count;
	logic [CW-1:0] push_n;
	logic [1:0] xfer;
	logic lo;
	logic pop;

	// wrap for any depth, not just powers of two
	function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] p);
		if (p == PW'(QUEUE_DEPTH - 1))
			return '0;
		return p + PW'(1);
	endfunction

	// ==============================
	// acceptance
	// ==============================
	assign xfer[0] = flags[0].jc | flags[0].rts | flags[0].take_branch;
	assign xfer[1] = flags[1].jc | flags[1].rts | flags[1].take_branch;
	// lowest valid slot goes first
	assign lo = ~slotv[0];
	assign q1 = (|slotv) & (count != DEPTH_C) & ~branchmiss;
	// a redirecting slot 0 ends acceptance for the bundle
	assign q2 = (&slotv) & ~xfer[0] & (count < DEPTH_C - CW'(1)) & ~branchmiss;
	assign pc_override = (q1 & xfer[lo]) | (q2 & xfer[1]);
	assign redirect_slot = q2 | lo;
	assign link_write = pc_override & flags[redirect_slot].jc;
	assign link_addr = slot_entry[redirect_slot].addr + addr_t'(SLOT_BYTES);

	// ==============================
	// storage
	// ==============================
	assign issue_valid = count != '0;
	assign issue_entry = mem[head];
	assign pop = issue_valid & issue_ready;
	assign tail_1 = ptr_inc(tail);
	assign push_n = q2 ? CW'(2) : CW'(q1);

	always_ff @(posedge clk) begin
		if (q1)
			mem[tail] <= slot_entry[lo];
		if (q2)
			mem[tail_1] <= slot_entry[1];
	end

	always_ff @(posedge clk) begin
		if (rst || branchmiss) begin
			head <= '0;
			tail <= '0;
			count <= '0;
		end else begin
			if (pop)
				head <= ptr_inc(head);
			if (q2)
				tail <= ptr_inc(tail_1);
			else if (q1)
				tail <= tail_1;
			count <= count + push_n - CW'(pop);
		end
	end

endmodule

// ==== design/fetch_top.sv ====
/*
 * instruction fetch front end
 * ties pc generation, predecode, slot tracking and the issue queue together
 */
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*; #(
	parameter int QUEUE_DEPTH = 4
) (
	input logic clk,
	input logic rst,
	output addr_t fetch_addr,
	input bundle_t bundle,
	input logic phit,
	input logic branchmiss,
	input addr_t miss_target,
	output queue_entry_t issue_entry,
	output logic issue_valid,
	input logic issue_ready
);
	bundle_t held_bundle;
	addr_t bundle_addr;
	addr_t link_addr;
	addr_t slot_target [SLOT_COUNT];
	slot_flags_t flags [SLOT_COUNT];
	op_e slot_op [SLOT_COUNT];
	queue_entry_t slot_entry [SLOT_COUNT];
	logic [1:0] pc_mask;
	logic [1:0] slotvd;
	logic nextb, bundle_done, q1, q2;
	logic pc_override, redirect_slot, redirect_rts, link_write;

	// memory output moves on after nextb, keep the captured bundle
	always_ff @(posedge clk) begin
		if (nextb)
			held_bundle <= bundle;
	end

	assign redirect_rts = flags[redirect_slot].rts;

	// queue entries built from the captured bundle
	assign slot_entry[0] = '{addr: bundle_addr, word: held_bundle.slot0, op: slot_op[0]};
	assign slot_entry[1] = '{addr: bundle_addr + addr_t'(SLOT_BYTES),
		word: held_bundle.slot1, op: slot_op[1]};

	pc_gen u_pc_gen (
		.clk(clk), .rst(rst), .phit(phit), .bundle_done(bundle_done),
		.pc_override(pc_override), .redirect_slot(redirect_slot),
		.redirect_rts(redirect_rts), .slot_target(slot_target),
		.link_write(link_write), .link_addr(link_addr), .branchmiss(branchmiss),
		.miss_target(miss_target), .fetch_addr(fetch_addr),
		.bundle_addr(bundle_addr), .pc_mask(pc_mask), .nextb(nextb)
	);

	predecode u_predecode (
		.bundle(held_bundle), .bundle_addr(bundle_addr), .flags(flags),
		.slot_target(slot_target), .slot_op(slot_op)
	);

	// queue sees the registered validity, the remainder is internal
	slot_valid u_slot_valid (
		.clk(clk), .rst(rst), .nextb(nextb), .branchmiss(branchmiss),
		.q1(q1), .q2(q2), .pc_override(pc_override), .pc_mask(pc_mask),
		.slotv(), .slotvd(slotvd), .bundle_done(bundle_done)
	);

	issue_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_issue_queue (
		.clk(clk), .rst(rst), .slotv(slotvd), .slot_entry(slot_entry),
		.flags(flags), .branchmiss(branchmiss), .issue_ready(issue_ready),
		.q1(q1), .q2(q2), .pc_override(pc_override), .redirect_slot(redirect_slot),
		.link_write(link_write), .link_addr(link_addr),
		.issue_entry(issue_entry), .issue_valid(issue_valid)
	);

endmodule

// ==== bench/fetch_tb.sv ====
/*
 * fetch front end testbench
 * instruction memory model, trace-driven stimulus and issue order checks
 */
`timescale 1ns/1ps

module fetch_tb import fetch_pkg::*; ();
	logic clk;
	logic rst;
	logic phit;
	logic branchmiss;
	logic issue_ready;
	logic issue_valid;
	addr_t fetch_addr;
	addr_t miss_target;
	bundle_t bundle;
	queue_entry_t issue_entry;

	// 64 bundles cover 0x00 to 0xff
	bundle_t imem [64];
	logic [39:0] trace [64];
	addr_t exp_addr [$];
	instr_t exp_word [$];
	int exp_idx;
	int stim_len;
	int limit;
	int cycle_cnt;
	integer seed;

	fetch_top #(.QUEUE_DEPTH(4)) uut (
		.clk(clk), .rst(rst), .fetch_addr(fetch_addr), .bundle(bundle),
		.phit(phit), .branchmiss(branchmiss), .miss_target(miss_target),
		.issue_entry(issue_entry), .issue_valid(issue_valid),
		.issue_ready(issue_ready)
	);

	// plain opcode, word follows the address
	function automatic instr_t fill_word(input addr_t a);
		return {2'b00, a[13:0] ^ {12'h000, a[15:14]}};
	endfunction

	// stimulus record: kind, cycles, phit, ready mode, branchmiss, miss target
	task automatic drive_record(input logic [39:0] r);
		logic [31:0] draw;
		phit = r[24];
		branchmiss = r[16];
		miss_target = r[15:0];
		draw = $random(seed);
		// mode 2 lets the cycle stall at random
		case (r[23:20])
			4'h0: issue_ready = 1'b0;
			4'h2: issue_ready = draw[0];
			default: issue_ready = 1'b1;
		endcase
	endtask

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// memory answers one cycle after the request
	always @(posedge clk) begin
		bundle <= imem[fetch_addr[7:2]];
	end

	// ==============================
	// issue order check
	// ==============================
	// the opcode field is the top two bits of the expected word
	always @(posedge clk) begin
		if (!rst && issue_valid && issue_ready && exp_idx < exp_addr.size()) begin
			assert (issue_entry.addr == exp_addr[exp_idx] &&
				issue_entry.word == exp_word[exp_idx] &&
				issue_entry.op == op_e'(exp_word[exp_idx][15:14])) else begin
				$display("MISMATCH at %0t: issued %h word %h op %0d, expected %h word %h",
					$time, issue_entry.addr, issue_entry.word, issue_entry.op,
					exp_addr[exp_idx], exp_word[exp_idx]);
				$display("Simulation finished: FAIL");
				$fatal(1, "issue order check failed");
			end
			exp_idx++;
		end
	end

	// run limit in cycles after reset
	always @(posedge clk) begin
		if (!rst) begin
			cycle_cnt++;
			if (cycle_cnt > limit) begin
				$display("timeout: expected issue sequence not finished at %0t", $time);
				$display("Simulation finished: FAIL");
				$fatal(1, "run limit reached");
			end
		end
	end

	initial begin
		rst = 1'b1;
		phit = 1'b0;
		branchmiss = 1'b0;
		issue_ready = 1'b0;
		miss_target = '0;
		bundle <= '0;
		exp_idx = 0;
		stim_len = 0;
		cycle_cnt = 0;
		seed = 32'hcd8d;
		for (int i = 0; i < 64; i++) begin
			trace[i] = '0;
			imem[i].slot0 = fill_word(addr_t'(i * 4));
			imem[i].slot1 = fill_word(addr_t'(i * 4 + 2));
		end
		// jump to 0x1a, backward branch to 0x0c, return
		imem[1].slot1 = 16'h400d;
		imem[4].slot0 = 16'hfffe;
		imem[7].slot0 = 16'h8000;
		$readmemh("bench/fetch_trace.txt", trace);
		for (int i = 0; i < 64; i++) begin
			if (trace[i][39:36] == 4'h1) begin
				stim_len += int'(trace[i][35:28]);
			end else if (trace[i][39:36] == 4'h2) begin
				exp_addr.push_back(trace[i][31:16]);
				exp_word.push_back(trace[i][15:0]);
			end
		end
		limit = stim_len * 4;
		repeat (3) @(posedge clk);
		#2;
		rst = 1'b0;
		// front end leaves reset idle at address zero
		assert (fetch_addr == '0 && !issue_valid) else begin
			$display("MISMATCH at %0t: reset state fetch_addr %h issue_valid %b, expected 0 and 0",
				$time, fetch_addr, issue_valid);
			$display("Simulation finished: FAIL");
			$fatal(1, "reset state check failed");
		end
		// ==============================
		// replay the trace
		// ==============================
		for (int i = 0; i < 64; i++) begin
			if (trace[i][39:36] == 4'h1) begin
				for (int k = 0; k < int'(trace[i][35:28]); k++) begin
					drive_record(trace[i]);
					@(posedge clk);
					#2;
				end
			end
		end
		// free running until the expected sequence is used up
		phit = 1'b1;
		branchmiss = 1'b0;
		issue_ready = 1'b1;
		while (exp_idx < exp_addr.size())
			@(posedge clk);
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

// ==== bench/fetch_trace.txt ====
// stimulus: 1_cycles_phit_ready(0 low, 1 high, 2 random)_branchmiss_misstarget
// expected issue: 2_0_addr_word, in issue order
1_1A_1_1_0_0000
1_01_1_1_1_0020
1_04_1_1_0_0000
1_0A_1_0_0_0000
1_14_1_2_0_0000
1_0A_1_1_0_0000
2_0_0000_0000
2_0_0002_0002
2_0_0004_0004
2_0_0006_400D
2_0_001A_001A
2_0_001C_8000
2_0_0008_0008
2_0_000A_000A
2_0_000C_000C
2_0_000E_000E
2_0_0010_FFFE
2_0_000C_000C
2_0_000E_000E
2_0_0010_FFFE
2_0_000C_000C
2_0_000E_000E
2_0_0020_0020
2_0_0022_0022
2_0_0024_0024
2_0_0026_0026
2_0_0028_0028
2_0_002A_002A
2_0_002C_002C
2_0_002E_002E
2_0_0030_0030
2_0_0032_0032
2_0_0034_0034
2_0_0036_0036

// ==== sources.f ====
common/fetch_pkg.sv
design/pc_gen.sv
design/predecode.sv
design/slot_valid.sv
design/issue_queue.sv
design/fetch_top.sv
bench/fetch_tb.sv

// ==== run.sh ====
#!/bin/bash
# build and run the fetch front end testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary -f sources.f --top-module fetch_tb -o fetch_sim \
	&& ./obj_dir/fetch_sim \
	|| exit 1
